// ==== hw/spi_pkg.sv ====
/*
 * Shared types and constants of the SPI master. Every RTL file refers to
 * them with scoped names: widths, register map, bus and status structs
 */
package spi_pkg;

   // ******************************
   // Widths with a meaning
   // ******************************
   typedef logic [7:0]  byte_t;        // One SPI data byte
   typedef logic [11:0] clkdiv_t;      // SCK divisor, half period = clkdiv+1 clocks
   typedef logic [2:0]  reg_addr_t;    // Register index
   typedef logic [15:0] reg_data_t;    // Register bus data
   typedef logic [6:0]  irq_vec_t;     // Interrupt sources, enables or flags
   typedef logic [1:0]  slave_sel_t;   // Slave select field

   // Slave select codes
   localparam slave_sel_t SEL_NONE   = 2'd0;
   localparam slave_sel_t SEL_FLASH  = 2'd1;
   localparam slave_sel_t SEL_LCD    = 2'd2;
   localparam slave_sel_t SEL_SDCARD = 2'd3;

   // ******************************
   // Register map
   // ******************************
   localparam reg_addr_t ADDR_CTRL   = 3'd0;   // Control / status
   localparam reg_addr_t ADDR_CLKDIV = 3'd1;   // Clock divisor
   localparam reg_addr_t ADDR_IE     = 3'd2;   // Interrupt enables
   localparam reg_addr_t ADDR_IF     = 3'd3;   // Interrupt flags, write 1 clears
   localparam reg_addr_t ADDR_DATA   = 3'd4;   // TX push on write, RX pop on read

   // Bit positions in the control / status word
   localparam int CTRL_TRANSFER_EN = 2;
   localparam int CTRL_RX_DISCARD  = 3;
   localparam int CTRL_TX_CLR      = 6;   // Write-only strobe
   localparam int CTRL_RX_CLR      = 7;   // Write-only strobe
   localparam int STAT_BUSY        = 15;

   typedef struct packed {
      logic      wr;      // Write strobe
      logic      rd;      // Read strobe
      reg_addr_t addr;
      reg_data_t wdata;
   } bus_req_t;

   typedef struct packed {
      slave_sel_t slave_sel;
      logic       transfer_en;   // Allow the controller to drain the TX FIFO
      logic       rx_discard;    // Drop received bytes
   } ctrl_t;

   typedef struct packed {
      logic exists;      // Not empty
      logic full;
      logic half_full;   // At or above the half level
   } fifo_stat_t;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_FIFO_RW,
      ST_TRANSFER,
      ST_RX_FULL
   } spi_state_e;

endpackage

// ==== hw/spi_fifo.sv ====
/*
 * Synchronous byte FIFO with exists, full and half-full flags.
 * Push when full and pop when empty are ignored; clr empties it
 */
`timescale 1ns/10ps

module spi_fifo #(
   parameter int FIFO_DEPTH = 32,
   parameter int HALF_LEVEL = 16
) (
   input  logic                clk,
   input  logic                rstn,
   input  logic                clr,
   input  spi_pkg::byte_t      din,
   input  logic                push,
   input  logic                pop,
   output spi_pkg::byte_t      dout,
   output spi_pkg::fifo_stat_t stat
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   spi_pkg::byte_t   mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr, rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push, do_pop;

   // Circular pointer advance, any depth
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign do_push = push && !stat.full;     // Dropped when full
   assign do_pop  = pop && stat.exists;     // Nothing when empty

   always_ff @(posedge clk)
   begin
      if (!rstn || clr)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= next_ptr(wr_ptr);
         if (do_pop)
            rd_ptr <= next_ptr(rd_ptr);
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;         // Idle or push+pop
         endcase
      end
   end

   // Storage
   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= din;
   end

   assign dout = mem[rd_ptr];   // First-word fall-through

   assign stat = '{exists:    (count != '0),
                   full:      (count == CNT_W'(FIFO_DEPTH)),
                   half_full: (count >= CNT_W'(HALF_LEVEL))};

endmodule

// ==== hw/spi_sck_gen.sv ====
/*
 * SCK generator. Divides clk by 2*(clkdiv+1), issues one-cycle rise and
 * fall strobes and drives the registered spi_clk while enabled
 */
`timescale 1ns/10ps

module spi_sck_gen (
   input  logic             clk,
   input  logic             rstn,
   input  spi_pkg::clkdiv_t clkdiv,
   input  logic             sck_en,     // High while a byte is shifting
   output logic             sck_rise,
   output logic             sck_fall,
   output logic             spi_clk
);

   spi_pkg::clkdiv_t div_cnt;
   logic             tc;         // Terminal count
   logic             int_sck;    // Free-running internal clock

   assign tc = (div_cnt == '0);

   // Down-counter, reload at terminal count
   always_ff @(posedge clk)
   begin
      if (!rstn)
         div_cnt <= '0;
      else if (tc)
         div_cnt <= clkdiv;
      else
         div_cnt <= div_cnt - 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         int_sck  <= 1'b0;
         sck_rise <= 1'b0;
         sck_fall <= 1'b0;
      end
      else
      begin
         if (tc)
            int_sck <= ~int_sck;
         sck_rise <= tc & ~int_sck;   // Strobes alternate every clkdiv+1 clocks
         sck_fall <= tc &  int_sck;
      end
   end

   // Output clock, low on every fall, high only when enabled
   always_ff @(posedge clk)
   begin
      if (!rstn)
         spi_clk <= 1'b0;
      else if (sck_fall)
         spi_clk <= 1'b0;
      else if (sck_rise && sck_en)
         spi_clk <= 1'b1;
   end

endmodule

// ==== hw/spi_shifter.sv ====
/*
 * Transmit and receive shift registers, MSB first. MOSI changes on
 * SCK fall strobes, MISO is sampled on rise strobes of a transfer
 */
`timescale 1ns/10ps

module spi_shifter (
   input  logic           clk,
   input  logic           sck_rise,
   input  logic           sck_fall,
   input  logic           tx_pop,    // Load pulse, coincides with a fall strobe
   input  logic           shift,     // Bit pulse from the controller
   input  spi_pkg::byte_t tx_byte,   // Front of the TX FIFO
   input  logic           miso,
   output logic           mosi,
   output spi_pkg::byte_t rx_byte
);

   spi_pkg::byte_t tx_shr;

   // ******************************
   // Transmit side
   // ******************************
   always_ff @(posedge clk)
   begin
      if (tx_pop)
         tx_shr <= tx_byte;
      else if (shift)
         tx_shr <= {tx_shr[6:0], 1'b0};   // Next bit moves to the top
   end

   // Registered MOSI
   always_ff @(posedge clk)
   begin
      if (sck_fall)
         mosi <= tx_pop ? tx_byte[7] : tx_shr[7];
   end

   // ******************************
   // Receive side
   // ******************************
   always_ff @(posedge clk)
   begin
      if (sck_rise && shift)
         rx_byte <= {rx_byte[6:0], miso};   // MSB arrives first
   end

endmodule

// ==== hw/spi_ctrl.sv ====
/*
 * Byte-transfer controller. Pulls bytes from the TX FIFO on SCK fall
 * strobes, counts eight rise strobes per byte and pushes the result
 */
`timescale 1ns/10ps

module spi_ctrl (
   input  logic                clk,
   input  logic                rstn,
   input  spi_pkg::ctrl_t      ctrl,
   input  spi_pkg::fifo_stat_t tx_stat,
   input  spi_pkg::fifo_stat_t rx_stat,
   input  logic                sck_rise,
   input  logic                sck_fall,
   output logic                sck_en,
   output logic                tx_pop,
   output logic                rx_push,
   output logic                shift,
   output logic                busy
);

   spi_pkg::spi_state_e state;
   logic [2:0]          bit_cnt;    // Bits left after the current one
   logic                rx_valid;   // Shifter holds a finished byte
   logic                load_ok;

   assign load_ok = tx_stat.exists && ctrl.transfer_en;

   // ******************************
   // State machine
   // ******************************
   always_ff @(posedge clk)
   begin
      if (!rstn)
         state <= spi_pkg::ST_IDLE;
      else
      begin
         case (state)
            spi_pkg::ST_IDLE:
               if (load_ok)
                  state <= spi_pkg::ST_FIFO_RW;
            spi_pkg::ST_FIFO_RW:
               if (sck_fall)   // Load next byte or stop
                  state <= load_ok ? spi_pkg::ST_TRANSFER : spi_pkg::ST_IDLE;
            spi_pkg::ST_TRANSFER:
               if (sck_rise && (bit_cnt == 3'd0))
                  state <= rx_stat.full ? spi_pkg::ST_RX_FULL : spi_pkg::ST_FIFO_RW;
            spi_pkg::ST_RX_FULL:
               if (!rx_stat.full)   // Wait for a host pop
                  state <= spi_pkg::ST_FIFO_RW;
            default:
               state <= spi_pkg::ST_IDLE;
         endcase
      end
   end

   // Bit counter, preset while waiting for a load
   always_ff @(posedge clk)
   begin
      if (!rstn)
         bit_cnt <= 3'd0;
      else if (state == spi_pkg::ST_FIFO_RW)
         bit_cnt <= 3'd7;
      else if (shift)
         bit_cnt <= bit_cnt - 3'd1;
   end

   // Received byte pending, held through the RX full stall
   always_ff @(posedge clk)
   begin
      if (!rstn)
         rx_valid <= 1'b0;
      else if ((state == spi_pkg::ST_IDLE) || (state == spi_pkg::ST_FIFO_RW)
               || ctrl.rx_discard)
         rx_valid <= 1'b0;
      else if (state == spi_pkg::ST_TRANSFER)
         rx_valid <= 1'b1;
   end

   // Strobes to the FIFOs and shifter
   assign tx_pop  = (state == spi_pkg::ST_FIFO_RW) && sck_fall && load_ok;
   assign rx_push = (state == spi_pkg::ST_FIFO_RW) && rx_valid;   // First cycle only
   assign shift   = (state == spi_pkg::ST_TRANSFER) && sck_rise;

   assign sck_en = (state == spi_pkg::ST_TRANSFER);
   assign busy   = (state != spi_pkg::ST_IDLE);

endmodule

// ==== hw/spi_regs.sv ====
/*
 * Host register file of the SPI master: control, divisor, interrupt
 * enable and flag registers, FIFO strobes, chip select outputs and irq
 */
`timescale 1ns/10ps

module spi_regs (
   input  logic                clk,
   input  logic                rstn,
   input  spi_pkg::bus_req_t   bus,
   output spi_pkg::reg_data_t  rdata,
   output spi_pkg::ctrl_t      ctrl,
   output spi_pkg::clkdiv_t    clkdiv,
   output logic                tx_push,
   output logic                tx_clr,
   output logic                rx_pop,
   output logic                rx_clr,
   input  spi_pkg::fifo_stat_t tx_stat,
   input  spi_pkg::fifo_stat_t rx_stat,
   input  spi_pkg::byte_t      rx_byte_out,
   input  logic                busy,
   output logic                irq,
   output logic                flash_csn,
   output logic                lcd_csn,
   output logic                sdcard_csn
);

   logic               wr_ctrl, wr_clkdiv, wr_ie, wr_if;
   spi_pkg::irq_vec_t  ie_q, if_q;
   spi_pkg::irq_vec_t  src, src_q;
   spi_pkg::irq_vec_t  if_clr;
   spi_pkg::reg_data_t status;

   // Write decode
   assign wr_ctrl   = bus.wr && (bus.addr == spi_pkg::ADDR_CTRL);
   assign wr_clkdiv = bus.wr && (bus.addr == spi_pkg::ADDR_CLKDIV);
   assign wr_ie     = bus.wr && (bus.addr == spi_pkg::ADDR_IE);
   assign wr_if     = bus.wr && (bus.addr == spi_pkg::ADDR_IF);

   // FIFO strobes, full/empty guarded inside the FIFO
   assign tx_push = bus.wr && (bus.addr == spi_pkg::ADDR_DATA);
   assign rx_pop  = bus.rd && (bus.addr == spi_pkg::ADDR_DATA);
   assign tx_clr  = wr_ctrl && bus.wdata[spi_pkg::CTRL_TX_CLR];
   assign rx_clr  = wr_ctrl && bus.wdata[spi_pkg::CTRL_RX_CLR];

   // ******************************
   // Control, divisor, enables
   // ******************************
   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         ctrl.slave_sel   <= spi_pkg::SEL_NONE;
         ctrl.transfer_en <= 1'b0;
         ctrl.rx_discard  <= 1'b0;
      end
      else if (wr_ctrl)
      begin
         ctrl.slave_sel   <= bus.wdata[1:0];
         ctrl.transfer_en <= bus.wdata[spi_pkg::CTRL_TRANSFER_EN];
         ctrl.rx_discard  <= bus.wdata[spi_pkg::CTRL_RX_DISCARD];
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         clkdiv <= '0;
         ie_q   <= '0;
      end
      else
      begin
         if (wr_clkdiv)
            clkdiv <= bus.wdata[11:0];
         if (wr_ie)
            ie_q <= bus.wdata[6:0];
      end
   end

   // Registered chip selects, active low
   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         flash_csn  <= 1'b1;
         lcd_csn    <= 1'b1;
         sdcard_csn <= 1'b1;
      end
      else
      begin
         flash_csn  <= (ctrl.slave_sel != spi_pkg::SEL_FLASH);
         lcd_csn    <= (ctrl.slave_sel != spi_pkg::SEL_LCD);
         sdcard_csn <= (ctrl.slave_sel != spi_pkg::SEL_SDCARD);
      end
   end

   // ******************************
   // Interrupts
   // ******************************
   assign src[0] = ~tx_stat.full;        // TX not full
   assign src[1] = ~tx_stat.half_full;   // TX below half
   assign src[2] = ~tx_stat.exists;      // TX empty
   assign src[3] = rx_stat.full;
   assign src[4] = rx_stat.half_full;
   assign src[5] = rx_stat.exists;       // RX not empty
   assign src[6] = ~busy;                // Transfer done

   assign if_clr = wr_if ? bus.wdata[6:0] : '0;

   // Rising edge sets a flag, set beats a same-cycle clear
   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         src_q <= 7'b100_0111;   // Source levels right after reset
         if_q  <= '0;
         irq   <= 1'b0;
      end
      else
      begin
         src_q <= src;
         if_q  <= (if_q & ~if_clr) | (src & ~src_q);
         irq   <= |(ie_q & if_q);
      end
   end

   // Status word, TX flags read inverted
   always_comb
   begin
      status                            = '0;
      status[1:0]                       = ctrl.slave_sel;
      status[spi_pkg::CTRL_TRANSFER_EN] = ctrl.transfer_en;
      status[spi_pkg::CTRL_RX_DISCARD]  = ctrl.rx_discard;
      status[14:9]                      = src[5:0];
      status[spi_pkg::STAT_BUSY]        = busy;
   end

   // Read mux
   always_comb
   begin
      case (bus.addr)
         spi_pkg::ADDR_CTRL:   rdata = status;
         spi_pkg::ADDR_CLKDIV: rdata = {4'd0, clkdiv};
         spi_pkg::ADDR_IE:     rdata = {9'd0, ie_q};
         spi_pkg::ADDR_IF:     rdata = {9'd0, if_q};
         spi_pkg::ADDR_DATA:   rdata = {8'd0, rx_byte_out};   // Front of RX FIFO
         default:              rdata = '0;
      endcase
   end

endmodule

// ==== hw/spi_master_top.sv ====
/*
 * Memory-mapped SPI master for flash, LCD and microSD slaves.
 * Host registers on a strobe bus, byte FIFOs in both directions
 */
`timescale 1ns/10ps

module spi_master_top #(
   parameter int FIFO_DEPTH = 32
) (
   input  logic               clk,
   input  logic               rstn,
   input  spi_pkg::bus_req_t  bus,
   output spi_pkg::reg_data_t rdata,
   output logic               irq,
   output logic               flash_csn,
   output logic               lcd_csn,
   output logic               sdcard_csn,
   output logic               spi_clk,
   output logic               mosi,
   input  logic               miso
);

   spi_pkg::ctrl_t      ctrl;
   spi_pkg::clkdiv_t    clkdiv;
   spi_pkg::fifo_stat_t tx_stat, rx_stat;
   spi_pkg::byte_t      tx_byte;       // TX FIFO front to shifter
   spi_pkg::byte_t      rx_byte;       // Shifter to RX FIFO
   spi_pkg::byte_t      rx_byte_out;   // RX FIFO front to host
   logic                tx_push, tx_clr, rx_pop, rx_clr;
   logic                sck_rise, sck_fall, sck_en;
   logic                tx_pop, rx_push, shift, busy;

   spi_regs u_regs (
      .clk, .rstn, .bus, .rdata, .ctrl, .clkdiv,
      .tx_push, .tx_clr, .rx_pop, .rx_clr,
      .tx_stat, .rx_stat, .rx_byte_out, .busy,
      .irq, .flash_csn, .lcd_csn, .sdcard_csn
   );

   spi_sck_gen u_sck_gen (
      .clk, .rstn, .clkdiv, .sck_en, .sck_rise, .sck_fall, .spi_clk
   );

   spi_ctrl u_ctrl (
      .clk, .rstn, .ctrl, .tx_stat, .rx_stat, .sck_rise, .sck_fall,
      .sck_en, .tx_pop, .rx_push, .shift, .busy
   );

   spi_shifter u_shifter (
      .clk, .sck_rise, .sck_fall, .tx_pop, .shift, .tx_byte, .miso, .mosi, .rx_byte
   );

   // Host to SPI
   spi_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .HALF_LEVEL(FIFO_DEPTH / 2)) tx_fifo (
      .clk, .rstn, .clr(tx_clr), .din(bus.wdata[7:0]),
      .push(tx_push), .pop(tx_pop), .dout(tx_byte), .stat(tx_stat)
   );

   // SPI to host
   spi_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .HALF_LEVEL(FIFO_DEPTH / 2)) rx_fifo (
      .clk, .rstn, .clr(rx_clr), .din(rx_byte),
      .push(rx_push), .pop(rx_pop), .dout(rx_byte_out), .stat(rx_stat)
   );

endmodule

// ==== testbench/spi_master_assertions.sv ====
/*
 * Concurrent checks on the SPI master, bound into spi_master_top.
 * Covers chip selects, idle SCK, irq source and the RX discard mode
 */
`timescale 1ns/10ps

module spi_master_assertions (
   input logic              clk,
   input logic              rstn,
   input spi_pkg::ctrl_t    ctrl,
   input logic              busy,
   input logic              rx_push,
   input logic              spi_clk,
   input logic              irq,
   input spi_pkg::irq_vec_t ie_q,
   input spi_pkg::irq_vec_t if_q,
   input logic              flash_csn,
   input logic              lcd_csn,
   input logic              sdcard_csn
);

   int         fail_count = 0;   // Assertion failures so far
   logic [2:0] csn_exp;          // Active-low {flash, lcd, sdcard}

   // Only the selected slave goes low
   always_comb
   begin
      case (ctrl.slave_sel)
         spi_pkg::SEL_FLASH:  csn_exp = 3'b011;
         spi_pkg::SEL_LCD:    csn_exp = 3'b101;
         spi_pkg::SEL_SDCARD: csn_exp = 3'b110;
         default:             csn_exp = 3'b111;   // No slave
      endcase
   end

   // ******************************
   // Chip selects
   // ******************************
   a_csn_follow: assert property (@(posedge clk) disable iff (!rstn)
      {flash_csn, lcd_csn, sdcard_csn} == $past(csn_exp))   // One cycle behind
      else
      begin
         fail_count++;
         $error("Chip selects do not follow slave_sel");
      end

   // SCK parked low between transfers
   a_sck_idle: assert property (@(posedge clk) disable iff (!rstn)
      !busy |-> !spi_clk)
      else
      begin
         fail_count++;
         $error("spi_clk high while not busy");
      end

   // irq only from an enabled, set flag
   a_irq_src: assert property (@(posedge clk) disable iff (!rstn)
      irq |-> $past(|(ie_q & if_q)))
      else
      begin
         fail_count++;
         $error("irq without an enabled flag");
      end

   // Nothing reaches the RX FIFO in discard mode
   a_rx_discard: assert property (@(posedge clk) disable iff (!rstn)
      (ctrl.rx_discard && $past(ctrl.rx_discard)) |-> !rx_push)
      else
      begin
         fail_count++;
         $error("RX push while rx_discard is set");
      end

endmodule

bind spi_master_top spi_master_assertions u_assertions (
   .clk, .rstn, .ctrl, .busy, .rx_push, .spi_clk, .irq,
   .ie_q(u_regs.ie_q), .if_q(u_regs.if_q),
   .flash_csn, .lcd_csn, .sdcard_csn
);

// ==== testbench/spi_master_tb.sv ====
/*
 * Testbench for spi_master_top, mosi looped back to miso. Runs reset,
 * chip select, loopback, discard, interrupt and RX stall tests in order
 */
`timescale 1ns/10ps

module spi_master_tb;

   localparam time CLK_PERIOD = 20ns;
   localparam time DRIVE_DLY  = 2ns;     // Input skew after the rising edge
   localparam int  POLL_LIMIT = 5000;    // Status reads per wait

   // Status word layout
   localparam int STAT_TX_NOT_FULL    = 9;
   localparam int STAT_TX_BELOW_HALF  = 10;
   localparam int STAT_TX_EMPTY       = 11;
   localparam int STAT_RX_FULL        = 12;
   localparam int STAT_RX_EXISTS      = 14;
   localparam int IRQ_DONE            = 6;   // Not-busy source
   localparam int RESET_STATUS        = (1 << STAT_TX_NOT_FULL) | (1 << STAT_TX_BELOW_HALF)
                                        | (1 << STAT_TX_EMPTY);

   logic               clk;
   logic               rstn;
   spi_pkg::bus_req_t  bus;
   spi_pkg::reg_data_t rdata;
   logic               irq, flash_csn, lcd_csn, sdcard_csn, spi_clk, mosi;

   int             tests_run, tests_failed, test_errs, assert_base;
   bit             timed_out;
   string          cur_test;
   spi_pkg::byte_t sent[$];   // Bytes in flight in send order

   spi_master_top #(.FIFO_DEPTH(32)) UUT (
      .clk, .rstn, .bus, .rdata, .irq, .flash_csn, .lcd_csn, .sdcard_csn,
      .spi_clk, .mosi, .miso(mosi)   // Loopback
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ******************************
   // Bus access
   // ******************************
   task automatic reg_write(input spi_pkg::reg_addr_t idx, input spi_pkg::reg_data_t data);
      @(posedge clk);
      #DRIVE_DLY;
      bus = '{wr: 1'b1, rd: 1'b0, addr: idx, wdata: data};
      @(posedge clk);
      #DRIVE_DLY;
      bus = '0;
   endtask

   task automatic reg_read(input spi_pkg::reg_addr_t idx, output spi_pkg::reg_data_t data);
      @(posedge clk);
      #DRIVE_DLY;
      bus = '{wr: 1'b0, rd: 1'b1, addr: idx, wdata: '0};
      @(negedge clk);
      data = rdata;   // Settled mid-cycle
      @(posedge clk);
      #DRIVE_DLY;
      bus = '0;
   endtask

   task automatic compare_value(input string what, input int expected, input int actual);
      if (expected != actual)
      begin
         test_errs++;
         $display("FAILED %s, %s: expected 0x%0h, actual 0x%0h",
                  cur_test, what, expected, actual);
      end
   endtask

   // Poll status until the masked bits match
   task automatic wait_status(input int mask, input int want, input string what);
      spi_pkg::reg_data_t st;
      int                 n;
      n = 0;
      reg_read(spi_pkg::ADDR_CTRL, st);
      while (((st & mask) != want) && (n < POLL_LIMIT))
      begin
         reg_read(spi_pkg::ADDR_CTRL, st);
         n++;
      end
      if ((st & mask) != want)
      begin
         timed_out = 1'b1;
         test_errs++;
         $display("%s: timed out waiting for %s", cur_test, what);
      end
   endtask

   task automatic wait_irq(input logic level);
      int n;
      n = 0;
      @(negedge clk);
      while ((irq !== level) && (n < POLL_LIMIT))
      begin
         @(negedge clk);
         n++;
      end
      if (irq !== level)
      begin
         timed_out = 1'b1;
         test_errs++;
         $display("%s: timed out waiting for irq to reach %b", cur_test, level);
      end
   endtask

   task automatic send_random(input int count);
      spi_pkg::byte_t b;
      for (int i = 0; i < count; i++)
      begin
         b = 8'($urandom);
         sent.push_back(b);
         wait_status(1 << STAT_TX_NOT_FULL, 1 << STAT_TX_NOT_FULL, "room in the TX FIFO");
         reg_write(spi_pkg::ADDR_DATA, {8'd0, b});
      end
   endtask

   // Transfers done once busy is low and TX is empty
   task automatic wait_transfers_done();
      wait_status((1 << spi_pkg::STAT_BUSY) | (1 << STAT_TX_EMPTY), 1 << STAT_TX_EMPTY,
                  "the transfers to finish");
   endtask

   task automatic start_test(input string name);
      cur_test    = name;
      test_errs   = 0;
      assert_base = UUT.u_assertions.fail_count;
   endtask

   task automatic finish_test();
      int fired;
      fired = UUT.u_assertions.fail_count - assert_base;
      if (fired != 0)
      begin
         test_errs++;
         $display("%s: %0d assertion check(s) fired", cur_test, fired);
      end
      tests_run++;
      if (test_errs == 0)
         $display("[pass] %s", cur_test);
      else
      begin
         tests_failed++;
         $display("[fail] %s, %0d error(s)", cur_test, test_errs);
      end
   endtask

   // ******************************
   // Tests
   // ******************************
   task automatic test_reset();
      spi_pkg::reg_data_t st;
      start_test("reset state");
      reg_read(spi_pkg::ADDR_CTRL, st);
      compare_value("status word", RESET_STATUS, st);
      compare_value("chip selects", 3'b111, {flash_csn, lcd_csn, sdcard_csn});
      compare_value("irq", 0, irq);
      finish_test();
   endtask

   task automatic test_chip_select();
      logic [2:0] exp;
      start_test("chip select");
      for (int s = 1; s <= 3; s++)
      begin
         reg_write(spi_pkg::ADDR_CTRL, 16'(s));
         @(posedge clk);   // Output register stage
         #DRIVE_DLY;
         exp        = 3'b111;
         exp[3 - s] = 1'b0;   // Flash is the top bit
         compare_value($sformatf("csn for select %0d", s), exp,
                       {flash_csn, lcd_csn, sdcard_csn});
      end
      reg_write(spi_pkg::ADDR_CTRL, 16'(spi_pkg::SEL_NONE));
      finish_test();
   endtask

   task automatic test_loopback();
      spi_pkg::reg_data_t rd;
      start_test("loopback");
      reg_write(spi_pkg::ADDR_CLKDIV, 16'd2);
      reg_write(spi_pkg::ADDR_CTRL, 16'((1 << spi_pkg::CTRL_TRANSFER_EN) | spi_pkg::SEL_FLASH));
      sent.delete();
      send_random(8);
      wait_transfers_done();
      for (int i = 0; i < 8; i++)
      begin
         reg_read(spi_pkg::ADDR_DATA, rd);
         compare_value($sformatf("byte %0d", i), sent[i], rd[7:0]);
      end
      reg_read(spi_pkg::ADDR_CTRL, rd);
      compare_value("rx not-empty flag", 0, rd[STAT_RX_EXISTS]);
      finish_test();
   endtask

   task automatic test_discard();
      spi_pkg::reg_data_t st;
      start_test("rx discard");
      reg_write(spi_pkg::ADDR_CTRL, 16'((1 << spi_pkg::CTRL_TRANSFER_EN)
                | (1 << spi_pkg::CTRL_RX_DISCARD) | spi_pkg::SEL_LCD));
      send_random(3);
      wait_transfers_done();
      reg_read(spi_pkg::ADDR_CTRL, st);
      compare_value("rx not-empty flag", 0, st[STAT_RX_EXISTS]);
      finish_test();
   endtask

   task automatic test_irq();
      spi_pkg::reg_data_t st;
      start_test("done interrupt");
      reg_write(spi_pkg::ADDR_IF, 16'h007f);   // Drop stale flags
      reg_write(spi_pkg::ADDR_IE, 16'(1 << IRQ_DONE));
      @(posedge clk);   // irq register sees the new enable
      #DRIVE_DLY;
      compare_value("irq before transfer", 0, irq);
      reg_write(spi_pkg::ADDR_CTRL, 16'((1 << spi_pkg::CTRL_TRANSFER_EN)
                | (1 << spi_pkg::CTRL_RX_DISCARD) | spi_pkg::SEL_SDCARD));
      send_random(1);
      wait_irq(1'b1);
      reg_read(spi_pkg::ADDR_IF, st);
      compare_value("done flag", 1, st[IRQ_DONE]);
      reg_write(spi_pkg::ADDR_IF, 16'(1 << IRQ_DONE));   // Write 1 clears
      @(posedge clk);
      #DRIVE_DLY;
      compare_value("irq after clear", 0, irq);
      reg_write(spi_pkg::ADDR_IE, 16'd0);
      finish_test();
   endtask

   task automatic test_rx_stall();
      spi_pkg::reg_data_t rd;
      bit                 held;
      int                 n;
      start_test("rx full stall");
      reg_write(spi_pkg::ADDR_CTRL, 16'((1 << spi_pkg::CTRL_TX_CLR) | (1 << spi_pkg::CTRL_RX_CLR)));
      reg_write(spi_pkg::ADDR_CTRL, 16'((1 << spi_pkg::CTRL_TRANSFER_EN) | spi_pkg::SEL_FLASH));
      sent.delete();
      send_random(33);   // One more than the RX FIFO holds
      wait_status((1 << STAT_TX_EMPTY) | (1 << STAT_RX_FULL),
                  (1 << STAT_TX_EMPTY) | (1 << STAT_RX_FULL), "TX drained into a full RX");
      held = 1'b1;
      n    = 0;
      while (held && (n < 100))   // Several byte times
      begin
         reg_read(spi_pkg::ADDR_CTRL, rd);
         held = rd[spi_pkg::STAT_BUSY];
         n++;
      end
      if (!held)
      begin
         test_errs++;
         $display("%s: busy dropped while the RX FIFO was full", cur_test);
      end
      reg_read(spi_pkg::ADDR_DATA, rd);
      compare_value("byte 0", sent[0], rd[7:0]);
      wait_status(1 << spi_pkg::STAT_BUSY, 0, "busy to fall after one read");
      for (int i = 1; i < 33; i++)
      begin
         reg_read(spi_pkg::ADDR_DATA, rd);
         compare_value($sformatf("byte %0d", i), sent[i], rd[7:0]);
      end
      reg_read(spi_pkg::ADDR_CTRL, rd);
      compare_value("rx not-empty flag", 0, rd[STAT_RX_EXISTS]);
      finish_test();
   endtask

   // ******************************
   // Main sequence
   // ******************************
   initial
   begin
      void'($urandom(32'hea52_3dda));
      rstn         = 1'b0;
      bus          = '0;
      tests_run    = 0;
      tests_failed = 0;
      timed_out    = 1'b0;
      repeat (4) @(posedge clk);
      #DRIVE_DLY;
      rstn = 1'b1;

      test_reset();
      if (!timed_out)
         test_chip_select();
      if (!timed_out)
         test_loopback();
      if (!timed_out)
         test_discard();
      if (!timed_out)
         test_irq();
      if (!timed_out)
         test_rx_stall();

      $display("Tests run %0d, passed %0d, failed %0d", tests_run,
               tests_run - tests_failed, tests_failed);
      if ((tests_failed == 0) && !timed_out)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

// ==== vlog.f ====
hw/spi_pkg.sv
hw/spi_fifo.sv
hw/spi_sck_gen.sv
hw/spi_shifter.sv
hw/spi_ctrl.sv
hw/spi_regs.sv
hw/spi_master_top.sv
testbench/spi_master_assertions.sv
testbench/spi_master_tb.sv

// ==== Bender.yml ====
package:
  name: spi_master

sources:
  - files:
      - hw/spi_pkg.sv
      - hw/spi_fifo.sv
      - hw/spi_sck_gen.sv
      - hw/spi_shifter.sv
      - hw/spi_ctrl.sv
      - hw/spi_regs.sv
      - hw/spi_master_top.sv
  - target: test
    files:
      - testbench/spi_master_assertions.sv
      - testbench/spi_master_tb.sv
